// ==== compile.f ====
+incdir+logic
logic/ctrl_pkg.sv
logic/special_decoder.sv
logic/special23_decoder.sv
logic/imm_decoder.sv
logic/controller.sv
dv/controller_props.sv
dv/controller_checker.sv
dv/controller_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the controller testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controllerTb -f compile.f

./obj_dir/VcontrollerTb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== dv/controller_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module controllerTb import ctrlPkg::*; ();

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 4;
    localparam int nRand       = 3;    // random variants per instruction
    localparam int nIllegalOp  = 16;
    localparam int nBadFunct   = 8;
    localparam int idleCycles  = 13;
    localparam int testCycles  = resetCycles + 27 + 5 * nRand + 7 * nRand
                               + nIllegalOp + nBadFunct + idleCycles;
    localparam int watchdogNs  = (testCycles + 50) * clkPeriod;

    // flag bits below aluOp, in control word order
    localparam logic [14:0] fAluSrc        = 15'h4000;
    localparam logic [14:0] fRegDst        = 15'h2000;
    localparam logic [14:0] fRegWrite      = 15'h1000;
    localparam logic [14:0] fWriteHi       = 15'h0800;
    localparam logic [14:0] fWriteLo       = 15'h0400;
    localparam logic [14:0] fHiOrLo        = 15'h0200;
    localparam logic [14:0] fHiLoReg       = 15'h0100;
    localparam logic [14:0] fMovEn         = 15'h0080;
    localparam logic [14:0] fMovz          = 15'h0040;
    localparam logic [14:0] fSignExtension = 15'h0020;
    localparam logic [14:0] fAdd64         = 15'h0010;
    localparam logic [14:0] fHiLoSelect    = 15'h0008;
    localparam logic [14:0] fRsRtMux       = 15'h0004;
    localparam logic [14:0] fHiRsSel       = 15'h0002;
    localparam logic [14:0] fSignExtImm    = 15'h0001;
    localparam logic [14:0] rdW            = fRegDst | fRegWrite;
    localparam logic [14:0] immW           = fAluSrc | fRegWrite;

    logic                Clk;
    logic                rst;
    logic [`INSTR_W-1:0] instr;
    logic                instrValid;
    ctrlT                expCtrl;
    logic                expIllegal;
    logic                ctrlValid;
    logic                illegalInstr;
    wire ctrlT           dutCtrl;
    int                  nTests;
    int                  nErrors;

    logic [`FUNCT_W-1:0] specialFns [23] = '{`FN_ADD, `FN_ADDU, `FN_AND, `FN_OR, `FN_XOR,
        `FN_NOR, `FN_SUB, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SLLV, `FN_SRA, `FN_SRAV, `FN_SRL,
        `FN_SRLV, `FN_MFHI, `FN_MFLO, `FN_MTHI, `FN_MTLO, `FN_MULT, `FN_MULTU, `FN_MOVN,
        `FN_MOVZ};
    logic [`OPCODE_W-1:0] immOps [7] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
        `OP_ANDI, `OP_ORI, `OP_XORI};

    controller i_controller (
        .Clk                 (Clk),
        .rst                 (rst),
        .instr               (instr),
        .instrValid          (instrValid),
        .ctrlValid           (ctrlValid),
        .illegalInstr        (illegalInstr),
        .aluOp               (dutCtrl.aluOp),
        .aluSrc              (dutCtrl.aluSrc),
        .regDst              (dutCtrl.regDst),
        .regWrite            (dutCtrl.regWrite),
        .writeHi             (dutCtrl.writeHi),
        .writeLo             (dutCtrl.writeLo),
        .hiOrLo              (dutCtrl.hiOrLo),
        .hiLoReg             (dutCtrl.hiLoReg),
        .movEn               (dutCtrl.movEn),
        .movz                (dutCtrl.movz),
        .signExtension       (dutCtrl.signExtension),
        .add64               (dutCtrl.add64),
        .hiLoSelect          (dutCtrl.hiLoSelect),
        .rsRtMux             (dutCtrl.rsRtMux),
        .hiRsSel             (dutCtrl.hiRsSel),
        .signExtendImmediate (dutCtrl.signExtendImmediate)
    );

    controllerChecker i_controllerChecker (.*);

    ////////////////////////////////////////////////////////////
    // expected control word from the instruction table
    ////////////////////////////////////////////////////////////

    function automatic ctrlT refDecode(input logic [`INSTR_W-1:0] ins, output logic illegal);
        logic [18:0] w;
        w       = '0;
        illegal = 1'b0;
        case (ins[31:26])
            `OP_SPECIAL: begin
                case (ins[5:0])
                    `FN_ADD, `FN_ADDU: w = {aluAdd, rdW};
                    `FN_AND:           w = {aluAnd, rdW};
                    `FN_OR:            w = {aluOr, rdW};
                    `FN_XOR:           w = {aluXor, rdW};
                    `FN_NOR:           w = {aluNor, rdW};
                    `FN_SUB:           w = {aluSub, rdW};
                    `FN_SLT, `FN_SLTU: w = {aluSlt, rdW};
                    `FN_SLL:           w = {aluSll, rdW | fRsRtMux};
                    `FN_SRA:           w = {aluSra, rdW | fRsRtMux};
                    `FN_SRL:           w = {ins[21] ? aluRotr : aluSrl, rdW | fRsRtMux};
                    `FN_SLLV:          w = {aluSll, rdW};
                    `FN_SRAV:          w = {aluSra, rdW};
                    `FN_SRLV:          w = {ins[6] ? aluRotr : aluSrl, rdW};
                    `FN_MFHI:          w = {aluAnd, rdW | fHiLoReg | fHiOrLo};
                    `FN_MFLO:          w = {aluAnd, rdW | fHiLoReg};
                    `FN_MTHI:          w = {aluAdd, fWriteHi | fHiRsSel};
                    `FN_MTLO:          w = {aluAdd, fWriteLo};
                    `FN_MULT:          w = {aluMult, fRegDst | fWriteHi | fWriteLo};
                    `FN_MULTU:         w = {aluMultu, fRegDst | fWriteHi | fWriteLo};
                    `FN_MOVN:          w = {aluSrl, fAluSrc | fRegDst | fMovEn};
                    `FN_MOVZ:          w = {aluSlt, fRegDst | fMovEn | fMovz};
                    default:           illegal = 1'b1;
                endcase
            end
            `OP_SPECIAL2: begin
                case (ins[5:0])
                    `FN_MADD: w = {aluMult, fWriteHi | fWriteLo | fAdd64 | fHiLoSelect};
                    `FN_MUL:  w = {aluMult, rdW};
                    default:  w = {aluMult, fWriteHi | fWriteLo | fHiLoSelect};  // msub
                endcase
            end
            `OP_SPECIAL3: w = {(ins[10:6] == `SA_SEH) ? aluSeh : aluSeb, rdW | fSignExtension};
            `OP_ADDI, `OP_ADDIU: w = {aluAdd, immW};
            `OP_SLTI, `OP_SLTIU: w = {aluSlt, immW};
            `OP_ANDI:            w = {aluAndi, immW | fSignExtImm};
            `OP_ORI:             w = {aluOr, immW | fSignExtImm};
            `OP_XORI:            w = {aluXor, immW | fSignExtImm};
            default:             illegal = 1'b1;
        endcase
        return ctrlT'(w);
    endfunction

    function automatic logic [`INSTR_W-1:0] randomInstr(input logic [`OPCODE_W-1:0] op,
                                                        input logic [`FUNCT_W-1:0] fn);
        logic [31:0] r;
        r = $urandom();
        return {op, r[25:6], fn};
    endfunction

    task automatic send(input logic [`INSTR_W-1:0] ins);
        @(negedge Clk);
        instr      = ins;
        instrValid = 1'b1;
        expCtrl    = refDecode(ins, expIllegal);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge Clk);
            instrValid = 1'b0;
            instr      = $urandom();             // must not disturb held word
        end
    endtask

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: tests did not finish within %0d ns", watchdogNs);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [`INSTR_W-1:0] ins;
        logic                ill;
        void'($urandom(32'h3170));
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        expCtrl    = '0;
        expIllegal = 1'b0;
        repeat (resetCycles) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        idle(3);                                 // ctrlValid low after reset
        foreach (specialFns[i]) begin
            send(randomInstr(`OP_SPECIAL, specialFns[i]));
        end
        ins     = randomInstr(`OP_SPECIAL, `FN_SRL);
        ins[21] = 1'b0;
        send(ins);
        ins[21] = 1'b1;                          // rotr
        send(ins);
        ins    = randomInstr(`OP_SPECIAL, `FN_SRLV);
        ins[6] = 1'b0;
        send(ins);
        ins[6] = 1'b1;                           // rotrv
        send(ins);
        idle(2);
        repeat (nRand) begin
            send(randomInstr(`OP_SPECIAL2, `FN_MADD));
            send(randomInstr(`OP_SPECIAL2, `FN_MUL));
            send(randomInstr(`OP_SPECIAL2, 6'h04));   // msub
            ins       = randomInstr(`OP_SPECIAL3, 6'h20);
            ins[10:6] = `SA_SEH;
            send(ins);
            ins[10:6] = 5'h10;                   // seb
            send(ins);
        end
        idle(2);
        foreach (immOps[i]) begin
            repeat (nRand) begin
                send(randomInstr(immOps[i], 6'($urandom())));
            end
        end
        idle(2);
        repeat (nIllegalOp) begin
            do begin
                ins = $urandom();
                void'(refDecode(ins, ill));
            end while (!ill || ins[31:26] == `OP_SPECIAL);
            send(ins);
        end
        repeat (nBadFunct) begin
            do begin
                ins = randomInstr(`OP_SPECIAL, 6'($urandom()));
                void'(refDecode(ins, ill));
            end while (!ill);
            send(ins);
        end
        idle(3);
        @(posedge Clk);                          // checker idle between edges
        $display("tests run: %0d, errors: %0d", nTests, nErrors);
        if (nErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/controller_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module controllerChecker import ctrlPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  logic [`INSTR_W-1:0] instr,
    input  logic                instrValid,
    input  ctrlT                expCtrl,
    input  logic                expIllegal,
    input  logic                ctrlValid,
    input  logic                illegalInstr,
    input  ctrlT                dutCtrl,
    output int                  nTests,
    output int                  nErrors
);

    logic                armed       = 1'b0;  // outputs defined once out of reset
    logic                pending     = 1'b0;  // strobe taken at last rising edge
    logic [`INSTR_W-1:0] lastInstr   = '0;
    ctrlT                lastCtrl    = '0;    // word the outputs must hold
    logic                lastIllegal = 1'b0;
    int                  testCount   = 0;
    int                  errCount    = 0;

    assign nTests  = testCount;
    assign nErrors = errCount;

    always begin
        @(posedge Clk);
        if (rst) begin
            armed       = 1'b0;
            pending     = 1'b0;
            lastCtrl    = '0;
            lastIllegal = 1'b0;
        end else begin
            armed   = 1'b1;
            pending = instrValid;
            if (instrValid) begin
                lastInstr   = instr;
                lastCtrl    = expCtrl;
                lastIllegal = expIllegal;
            end
        end
        @(negedge Clk);                               // outputs settled
        if (armed && ctrlValid !== pending) begin
            errCount++;
            $display("[FAIL] %0t ns: ctrlValid is %b, expected %b", $time, ctrlValid, pending);
        end
        if (armed && (dutCtrl !== lastCtrl || illegalInstr !== lastIllegal)) begin
            errCount++;
            $display("[FAIL] %0t ns: instr %h gave word %h illegal %b, expected %h illegal %b",
                     $time, lastInstr, dutCtrl, illegalInstr, lastCtrl, lastIllegal);
        end else if (armed && pending) begin
            $display("[ok]   %0t ns: instr %h word %h illegal %b",
                     $time, lastInstr, dutCtrl, illegalInstr);
        end
        if (armed && pending) begin
            testCount++;
        end
    end

endmodule

`default_nettype wire

// ==== dv/controller_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module controllerProps (
    input logic        Clk,
    input logic        rst,
    input logic        instrValid,
    input logic        ctrlValid,
    input logic        illegalInstr,
    input logic        movEn,
    input logic        regWrite,
    input logic [18:0] ctrlWord      // registered control word
);

    logic strobeSeen;

    always_ff @(posedge Clk) begin
        if (rst) begin
            strobeSeen <= 1'b0;
        end else if (instrValid) begin
            strobeSeen <= 1'b1;
        end
    end

    quietAfterReset: assert property (@(posedge Clk) disable iff (rst)
        !strobeSeen |-> !ctrlValid)
        else $error("ctrlValid went high before the first strobe");

    illegalIsZero: assert property (@(posedge Clk) disable iff (rst)
        illegalInstr |-> ctrlWord == '0)
        else $error("control word not zero on an illegal instruction");

    movNoWrite: assert property (@(posedge Clk) disable iff (rst)
        movEn |-> !regWrite)
        else $error("regWrite set together with movEn");

endmodule

bind controller controllerProps i_controllerProps (
    .Clk         (Clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .ctrlValid   (ctrlValid),
    .illegalInstr(illegalInstr),
    .movEn       (movEn),
    .regWrite    (regWrite),
    .ctrlWord    (ctrlQ)
);

`default_nettype wire

// ==== logic/controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module controller import ctrlPkg::*; (
    input  logic                Clk,
    input  logic                rst,
    input  logic [`INSTR_W-1:0] instr,
    input  logic                instrValid,
    output logic                ctrlValid,
    output logic                illegalInstr,
    output aluOpT               aluOp,
    output logic                aluSrc,
    output logic                regDst,
    output logic                regWrite,
    output logic                writeHi,
    output logic                writeLo,
    output logic                hiOrLo,
    output logic                hiLoReg,
    output logic                movEn,
    output logic                movz,
    output logic                signExtension,
    output logic                add64,
    output logic                hiLoSelect,
    output logic                rsRtMux,
    output logic                hiRsSel,
    output logic                signExtendImmediate
);

    decodeT specialRes;
    decodeT special23Res;
    decodeT immRes;
    ctrlT   selCtrl;
    ctrlT   ctrlQ;
    logic   selIllegal;

    specialDecoder   i_specialDecoder   (.instr(instr), .result(specialRes));
    special23Decoder i_special23Decoder (.instr(instr), .result(special23Res));
    immDecoder       i_immDecoder       (.instr(instr), .result(immRes));

    ////////////////////////////////////////////////////////////
    // pick the claiming decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (specialRes.hit) begin
            selCtrl = specialRes.ctrl;
        end else if (special23Res.hit) begin
            selCtrl = special23Res.ctrl;
        end else if (immRes.hit) begin
            selCtrl = immRes.ctrl;
        end else begin
            selCtrl = '0;                              // unknown opcode
        end
    end

    assign selIllegal = !(specialRes.hit || special23Res.hit || immRes.hit);

    ////////////////////////////////////////////////////////////
    // decode/execute pipeline register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            ctrlValid    <= 1'b0;
            illegalInstr <= 1'b0;
            ctrlQ        <= '0;
        end else begin
            ctrlValid <= instrValid;                   // one-cycle strobe
            if (instrValid) begin
                illegalInstr <= selIllegal;
                ctrlQ        <= selCtrl;               // held until next strobe
            end
        end
    end

    assign aluOp               = ctrlQ.aluOp;
    assign aluSrc              = ctrlQ.aluSrc;
    assign regDst              = ctrlQ.regDst;
    assign regWrite            = ctrlQ.regWrite;
    assign writeHi             = ctrlQ.writeHi;
    assign writeLo             = ctrlQ.writeLo;
    assign hiOrLo              = ctrlQ.hiOrLo;
    assign hiLoReg             = ctrlQ.hiLoReg;
    assign movEn               = ctrlQ.movEn;
    assign movz                = ctrlQ.movz;
    assign signExtension       = ctrlQ.signExtension;
    assign add64               = ctrlQ.add64;
    assign hiLoSelect          = ctrlQ.hiLoSelect;
    assign rsRtMux             = ctrlQ.rsRtMux;
    assign hiRsSel             = ctrlQ.hiRsSel;
    assign signExtendImmediate = ctrlQ.signExtendImmediate;

endmodule

`default_nettype wire

// ==== logic/imm_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module immDecoder import ctrlPkg::*; (
    input  logic [`INSTR_W-1:0] instr,
    output decodeT              result
);

    logic [`OPCODE_W-1:0] opcode;

    assign opcode = instr[`INSTR_W-1 -: `OPCODE_W];

    always_comb begin
        result = '0;
        case (opcode)
            `OP_ADDI, `OP_ADDIU: begin
                result.hit        = 1'b1;
                result.ctrl.aluOp = aluAdd;
            end
            `OP_SLTI, `OP_SLTIU: begin
                result.hit        = 1'b1;
                result.ctrl.aluOp = aluSlt;
            end
            `OP_ANDI: begin
                result.hit                      = 1'b1;
                result.ctrl.aluOp               = aluAndi;
                result.ctrl.signExtendImmediate = 1'b1;
            end
            `OP_ORI: begin
                result.hit                      = 1'b1;
                result.ctrl.aluOp               = aluOr;
                result.ctrl.signExtendImmediate = 1'b1;
            end
            `OP_XORI: begin
                result.hit                      = 1'b1;
                result.ctrl.aluOp               = aluXor;
                result.ctrl.signExtendImmediate = 1'b1;
            end
            default: begin
                result = '0;
            end
        endcase
        // every immediate op takes the immediate and writes rt
        result.ctrl.aluSrc   = result.hit;
        result.ctrl.regWrite = result.hit;
    end

endmodule

`default_nettype wire

// ==== logic/special23_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module special23Decoder import ctrlPkg::*; (
    input  logic [`INSTR_W-1:0] instr,
    output decodeT              result
);

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic [`SHAMT_W-1:0]  shamt;

    assign opcode = instr[`INSTR_W-1 -: `OPCODE_W];
    assign funct  = instr[`FUNCT_W-1:0];
    assign shamt  = instr[`FUNCT_W +: `SHAMT_W];

    always_comb begin
        result = '0;
        case (opcode)
            `OP_SPECIAL2: begin
                result.hit        = 1'b1;
                result.ctrl.aluOp = aluMult;
                if (funct == `FN_MUL) begin
                    result.ctrl.regDst   = 1'b1;   // low word to rd
                    result.ctrl.regWrite = 1'b1;
                end else begin
                    // madd and msub accumulate into hi/lo
                    result.ctrl.writeHi    = 1'b1;
                    result.ctrl.writeLo    = 1'b1;
                    result.ctrl.hiLoSelect = 1'b1;
                    result.ctrl.add64      = (funct == `FN_MADD);
                end
            end
            `OP_SPECIAL3: begin
                result.hit                = 1'b1;
                result.ctrl.aluOp         = (shamt == `SA_SEH) ? aluSeh : aluSeb;
                result.ctrl.regDst        = 1'b1;
                result.ctrl.regWrite      = 1'b1;
                result.ctrl.signExtension = 1'b1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/special_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defs.svh"

module specialDecoder import ctrlPkg::*; (
    input  logic [`INSTR_W-1:0] instr,
    output decodeT              result
);

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;

    assign opcode = instr[`INSTR_W-1 -: `OPCODE_W];
    assign funct  = instr[`FUNCT_W-1:0];

    ////////////////////////////////////////////////////////////
    // function code decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        result = '0;
        if (opcode == `OP_SPECIAL) begin
            // most SPECIAL ops write rd
            result.hit            = 1'b1;
            result.ctrl.regDst    = 1'b1;
            result.ctrl.regWrite  = 1'b1;
            case (funct)
                `FN_ADD, `FN_ADDU: begin
                    result.ctrl.aluOp = aluAdd;
                end
                `FN_AND: begin
                    result.ctrl.aluOp = aluAnd;
                end
                `FN_OR: begin
                    result.ctrl.aluOp = aluOr;
                end
                `FN_XOR: begin
                    result.ctrl.aluOp = aluXor;
                end
                `FN_NOR: begin
                    result.ctrl.aluOp = aluNor;
                end
                `FN_SUB: begin
                    result.ctrl.aluOp = aluSub;
                end
                `FN_SLT, `FN_SLTU: begin
                    result.ctrl.aluOp = aluSlt;
                end
                `FN_SLL: begin
                    result.ctrl.aluOp   = aluSll;
                    result.ctrl.rsRtMux = 1'b1;    // shift by shamt
                end
                `FN_SLLV: begin
                    result.ctrl.aluOp = aluSll;
                end
                `FN_SRA: begin
                    result.ctrl.aluOp   = aluSra;
                    result.ctrl.rsRtMux = 1'b1;
                end
                `FN_SRAV: begin
                    result.ctrl.aluOp = aluSra;
                end
                `FN_SRL: begin
                    result.ctrl.aluOp   = instr[21] ? aluRotr : aluSrl;
                    result.ctrl.rsRtMux = 1'b1;
                end
                `FN_SRLV: begin
                    result.ctrl.aluOp = instr[6] ? aluRotr : aluSrl;
                end
                `FN_MFHI: begin
                    result.ctrl.hiLoReg = 1'b1;
                    result.ctrl.hiOrLo  = 1'b1;
                end
                `FN_MFLO: begin
                    result.ctrl.hiLoReg = 1'b1;
                end
                `FN_MTHI: begin
                    result.ctrl.aluOp    = aluAdd;
                    result.ctrl.regDst   = 1'b0;
                    result.ctrl.regWrite = 1'b0;
                    result.ctrl.writeHi  = 1'b1;
                    result.ctrl.hiRsSel  = 1'b1;   // rs routed to hi
                end
                `FN_MTLO: begin
                    result.ctrl.aluOp    = aluAdd;
                    result.ctrl.regDst   = 1'b0;
                    result.ctrl.regWrite = 1'b0;
                    result.ctrl.writeLo  = 1'b1;
                end
                `FN_MULT, `FN_MULTU: begin
                    result.ctrl.aluOp    = (funct == `FN_MULT) ? aluMult : aluMultu;
                    result.ctrl.regWrite = 1'b0;   // product goes to hi/lo
                    result.ctrl.writeHi  = 1'b1;
                    result.ctrl.writeLo  = 1'b1;
                end
                `FN_MOVN: begin
                    result.ctrl.aluOp    = aluSrl;
                    result.ctrl.aluSrc   = 1'b1;
                    result.ctrl.regWrite = 1'b0;   // write decided by movEn path
                    result.ctrl.movEn    = 1'b1;
                end
                `FN_MOVZ: begin
                    result.ctrl.aluOp    = aluSlt;
                    result.ctrl.regWrite = 1'b0;
                    result.ctrl.movEn    = 1'b1;
                    result.ctrl.movz     = 1'b1;
                end
                default: begin
                    result = '0;                   // not ours
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ctrl_pkg.sv ====
`default_nettype none

package ctrlPkg;

    ////////////////////////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        aluAnd   = 4'd0,
        aluOr    = 4'd1,
        aluAdd   = 4'd2,
        aluXor   = 4'd3,
        aluNor   = 4'd4,
        aluSra   = 4'd5,
        aluSub   = 4'd6,
        aluSlt   = 4'd7,
        aluSll   = 4'd8,
        aluSrl   = 4'd9,
        aluMult  = 4'd10,
        aluMultu = 4'd11,
        aluRotr  = 4'd12,
        aluSeb   = 4'd13,
        aluSeh   = 4'd14,
        aluAndi  = 4'd15
    } aluOpT;

    ////////////////////////////////////////////////////////////
    // control word for the execute stage
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrc;               // immediate as operand b
        logic  regDst;               // rd, else rt
        logic  regWrite;
        logic  writeHi;
        logic  writeLo;
        logic  hiOrLo;               // hi on mfhi
        logic  hiLoReg;              // result from hi/lo
        logic  movEn;
        logic  movz;                 // movz, else movn
        logic  signExtension;        // seb/seh path
        logic  add64;                // madd accumulates up
        logic  hiLoSelect;           // accumulate into hi/lo
        logic  rsRtMux;              // shamt instead of rs
        logic  hiRsSel;
        logic  signExtendImmediate;
    } ctrlT;

    // what each group decoder hands back to the top
    typedef struct packed {
        logic hit;                   // decoder claims the opcode
        ctrlT ctrl;
    } decodeT;

endpackage

`default_nettype wire

// ==== logic/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

`define INSTR_W     32
`define OPCODE_W    6
`define FUNCT_W     6
`define SHAMT_W     5

// opcodes
`define OP_SPECIAL  6'h00
`define OP_SPECIAL2 6'h1c  // madd, mul, msub
`define OP_SPECIAL3 6'h1f  // seh, seb
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e

// SPECIAL function codes
`define FN_SLL      6'h00
`define FN_SRL      6'h02  // rotr when bit 21 set
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06  // rotrv when bit 6 set
`define FN_SRAV     6'h07
`define FN_MOVZ     6'h0a
`define FN_MOVN     6'h0b
`define FN_MFHI     6'h10
`define FN_MTHI     6'h11
`define FN_MFLO     6'h12
`define FN_MTLO     6'h13
`define FN_MULT     6'h18
`define FN_MULTU    6'h19
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// SPECIAL2 function codes
`define FN_MADD     6'h00
`define FN_MUL      6'h02

`define SA_SEH      5'h18  // shift field picking seh over seb

`endif
